//--- verilog/dcache_settings.svh
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// byte address split as tag | index | line offset
`define DCACHE_ADDR_BITS      32
`define DCACHE_OFFSET_BITS    6
`define DCACHE_INDEX_BITS     9
`define DCACHE_TAG_BITS       17

`define DCACHE_WORD_BITS      64
`define DCACHE_WORDS_PER_LINE 8
`define DCACHE_WAYS           2

`define DCACHE_LFSR_SEED      8'hFF

// derived from the values above
`define DCACHE_SETS           (1 << `DCACHE_INDEX_BITS)
`define DCACHE_WAY_BITS       ($clog2(`DCACHE_WAYS))
`define DCACHE_WORD_SEL_BITS  ($clog2(`DCACHE_WORDS_PER_LINE))
`define DCACHE_INDEX_LSB      `DCACHE_OFFSET_BITS
`define DCACHE_TAG_LSB        (`DCACHE_OFFSET_BITS + `DCACHE_INDEX_BITS)
`define DCACHE_WORD_SEL_LSB   (`DCACHE_OFFSET_BITS - `DCACHE_WORD_SEL_BITS)

`endif

//--- verilog/dcache_pkg.sv
`default_nettype none
`include "dcache_settings.svh"

package dcache_pkg;

    typedef logic [`DCACHE_ADDR_BITS-1:0] addr_t;
    typedef logic [`DCACHE_WORD_BITS-1:0] word_t;

    // word 0 sits in the low 64 bits of the line
    typedef word_t [`DCACHE_WORDS_PER_LINE-1:0] line_t;

    typedef struct packed {
        logic                        valid;
        logic                        dirty;
        logic [`DCACHE_TAG_BITS-1:0] tag;
    } tag_entry_t;

    // one entry per way, way 0 in the low bits
    typedef tag_entry_t [`DCACHE_WAYS-1:0] tag_set_t;

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } op_t;

endpackage

`default_nettype wire

//--- verilog/dcache_sram.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_sram #(
    parameter type entry_t   = logic [31:0],
    parameter int  DEPTH     = 512,
    localparam int ADDR_BITS = $clog2(DEPTH)
) (
    input  wire logic                 clock,
    input  wire logic                 enable,
    input  wire logic                 write,
    input  wire logic [ADDR_BITS-1:0] addr,
    input  wire entry_t               wdata,
    output entry_t                    rdata
);
    entry_t mem [DEPTH];

    always_ff @(posedge clock) begin
        if (enable) begin
            if (write) begin
                mem[addr] <= wdata;
            end else begin
                rdata <= mem[addr];   // held until the next read
            end
        end
    end

    // catches an index computed wider than the array
    assert property (@(posedge clock) enable |-> addr < DEPTH);

endmodule

`default_nettype wire

//--- verilog/dcache_way_select.sv
`timescale 1ns/1ps
`default_nettype none
`include "dcache_settings.svh"

module dcache_way_select (
    input  wire logic                        clock,
    input  wire logic                        reset_n,
    input  wire dcache_pkg::tag_set_t        tag_set,
    input  wire logic [`DCACHE_TAG_BITS-1:0] lookup_tag,
    input  wire logic                        advance,
    output logic                             hit,
    output logic                             hit_way,
    output logic                             victim_way,
    output logic                             victim_dirty,
    output logic [`DCACHE_TAG_BITS-1:0]      victim_tag
);
    logic [`DCACHE_WAYS-1:0] way_hit;
    logic [7:0]              lfsr;

    // x^8 + x^6 + x^5 + x^4 + 1
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            lfsr <= `DCACHE_LFSR_SEED;
        end else if (advance) begin
            lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
        end
    end

    always_comb begin
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            way_hit[w] = tag_set[w].valid && (tag_set[w].tag == lookup_tag);
        end
    end

    assign hit     = |way_hit;
    assign hit_way = way_hit[1];

    // first free way, else a pseudo-random one
    always_comb begin
        if (!tag_set[0].valid) begin
            victim_way = 1'b0;
        end else if (!tag_set[1].valid) begin
            victim_way = 1'b1;
        end else begin
            victim_way = lfsr[0];
        end
    end

    assign victim_dirty = tag_set[victim_way].valid && tag_set[victim_way].dirty;
    assign victim_tag   = tag_set[victim_way].tag;

    // a refill must never install a tag that the other way already holds
    assert property (@(posedge clock) disable iff (!reset_n)
        !$isunknown({tag_set, lookup_tag}) |-> !(&way_hit));

endmodule

`default_nettype wire

//--- verilog/dcache_line_merge.sv
`timescale 1ns/1ps
`default_nettype none
`include "dcache_settings.svh"

module dcache_line_merge (
    input  wire dcache_pkg::line_t                 line_in,
    input  wire logic [`DCACHE_WORD_SEL_BITS-1:0] word_sel,
    input  wire dcache_pkg::word_t                 wdata,
    input  wire dcache_pkg::word_t                 wmask,
    output dcache_pkg::line_t                      line_out,
    output dcache_pkg::word_t                      word_out
);
    dcache_pkg::word_t old_word;
    dcache_pkg::word_t new_word;

    assign old_word = line_in[word_sel];
    assign word_out = old_word;

    // mask bit 1 takes the store data
    assign new_word = (wdata & wmask) | (old_word & ~wmask);

    always_comb begin
        for (int w = 0; w < `DCACHE_WORDS_PER_LINE; w++) begin
            if (w == int'(word_sel)) begin
                line_out[w] = new_word;
            end else begin
                line_out[w] = line_in[w];
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/dcache_control.sv
`timescale 1ns/1ps
`default_nettype none
`include "dcache_settings.svh"

module dcache_control (
    input  wire logic                              clock,
    input  wire logic                              reset_n,
    // load/store port
    input  wire logic                              cpu_valid,
    output logic                                   cpu_ready,
    input  wire dcache_pkg::addr_t                 cpu_addr,
    input  wire dcache_pkg::op_t                   cpu_op,
    input  wire dcache_pkg::word_t                 cpu_wdata,
    input  wire dcache_pkg::word_t                 cpu_wmask,
    output logic                                   cpu_done,
    output dcache_pkg::word_t                      cpu_rdata,
    // memory port, whole lines
    output logic                                   mem_valid,
    input  wire logic                              mem_ready,
    output dcache_pkg::addr_t                      mem_addr,
    output dcache_pkg::op_t                        mem_op,
    output dcache_pkg::line_t                      mem_wdata,
    input  wire logic                              mem_done,
    input  wire dcache_pkg::line_t                 mem_rdata,
    // tag array
    output logic                                   tag_enable,
    output logic                                   tag_write,
    output logic [`DCACHE_INDEX_BITS-1:0]          tag_addr,
    output dcache_pkg::tag_set_t                   tag_wdata,
    input  wire dcache_pkg::tag_set_t              tag_rdata,
    // data array, addressed by {index, way}
    output logic                                   data_enable,
    output logic                                   data_write,
    output logic [`DCACHE_INDEX_BITS+`DCACHE_WAY_BITS-1:0] data_addr,
    output dcache_pkg::line_t                      data_wdata,
    input  wire dcache_pkg::line_t                 data_rdata,
    // way select
    input  wire logic                              hit,
    input  wire logic                              hit_way,
    input  wire logic                              victim_way,
    input  wire logic                              victim_dirty,
    input  wire logic [`DCACHE_TAG_BITS-1:0]       victim_tag,
    output logic [`DCACHE_TAG_BITS-1:0]            lookup_tag,
    output logic                                   advance,
    // line merge
    output dcache_pkg::line_t                      merge_line,
    output logic [`DCACHE_WORD_SEL_BITS-1:0]       merge_word_sel,
    output dcache_pkg::word_t                      merge_wdata,
    output dcache_pkg::word_t                      merge_wmask,
    input  wire dcache_pkg::line_t                 merged_line,
    input  wire dcache_pkg::word_t                 merged_word
);
    typedef enum logic [3:0] {
        INIT, IDLE, LOOKUP, READ_CACHE, RESPOND,
        WRITE_CACHE, WRITE_BACK, REFILL_REQ, REFILL_WAIT, REFILL
    } state_t;

    state_t                        state;
    state_t                        next_state;
    logic [`DCACHE_INDEX_BITS-1:0] init_idx;
    logic                          wb_sent;
    logic                          accept;
    logic [`DCACHE_INDEX_BITS-1:0] index_q;

    dcache_pkg::addr_t             addr_q;
    dcache_pkg::op_t               op_q;
    dcache_pkg::word_t             wdata_q;
    dcache_pkg::word_t             wmask_q;

    logic                          hit_q;
    logic                          way_q;     // hit way, or the victim on a miss
    logic [`DCACHE_TAG_BITS-1:0]   victim_tag_q;
    dcache_pkg::tag_set_t          set_q;
    dcache_pkg::tag_set_t          set_upd;
    dcache_pkg::line_t             refill_q;

    assign accept     = cpu_valid && cpu_ready;
    assign index_q    = addr_q[`DCACHE_TAG_LSB-1:`DCACHE_INDEX_LSB];
    assign lookup_tag = addr_q[`DCACHE_ADDR_BITS-1:`DCACHE_TAG_LSB];
    assign advance    = (state == LOOKUP) && !hit;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state <= INIT;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            INIT:        next_state = (init_idx == '1) ? IDLE : INIT;
            IDLE:        next_state = accept ? LOOKUP : IDLE;
            LOOKUP:      next_state = (hit || victim_dirty) ? READ_CACHE : REFILL_REQ;
            READ_CACHE: begin
                if (!hit_q) begin
                    next_state = WRITE_BACK;   // dirty victim
                end else if (op_q == dcache_pkg::OP_WRITE) begin
                    next_state = WRITE_CACHE;
                end else begin
                    next_state = RESPOND;
                end
            end
            WRITE_BACK:  next_state = mem_done ? REFILL_REQ : WRITE_BACK;
            REFILL_REQ:  next_state = mem_ready ? REFILL_WAIT : REFILL_REQ;
            REFILL_WAIT: next_state = mem_done ? REFILL : REFILL_WAIT;
            default:     next_state = IDLE;
        endcase
    end

    // init sweep and write-back handshake
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            init_idx <= '0;
            wb_sent  <= 1'b0;
        end else begin
            if (state == INIT) begin
                init_idx <= init_idx + 1'b1;
            end
            if (mem_done) begin
                wb_sent <= 1'b0;
            end else if ((state == WRITE_BACK) && mem_valid && mem_ready) begin
                wb_sent <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            addr_q <= '0;
            op_q   <= dcache_pkg::OP_READ;
            hit_q  <= 1'b0;
            way_q  <= 1'b0;
        end else begin
            if (accept) begin
                addr_q <= cpu_addr;
                op_q   <= cpu_op;
            end
            if (state == LOOKUP) begin
                hit_q <= hit;
                way_q <= hit ? hit_way : victim_way;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            wdata_q <= cpu_wdata;
            wmask_q <= cpu_wmask;
        end
        if (state == LOOKUP) begin
            victim_tag_q <= victim_tag;
            set_q        <= tag_rdata;
        end
        if ((state == REFILL_WAIT) && mem_done) begin
            refill_q <= mem_rdata;
        end
    end

    // new tag set for a write hit or a refill
    always_comb begin
        set_upd = set_q;
        if (state == REFILL) begin
            set_upd[way_q].valid = 1'b1;
            set_upd[way_q].dirty = (op_q == dcache_pkg::OP_WRITE);
            set_upd[way_q].tag   = lookup_tag;
        end else begin
            set_upd[way_q].dirty = 1'b1;
        end
    end

    always_comb begin
        tag_enable = 1'b0;
        tag_write  = 1'b0;
        tag_addr   = index_q;
        tag_wdata  = set_upd;
        case (state)
            INIT: begin
                tag_enable = 1'b1;
                tag_write  = 1'b1;
                tag_addr   = init_idx;
                tag_wdata  = '0;
            end
            IDLE: begin
                tag_enable = accept;   // tag set ready in LOOKUP
                tag_addr   = cpu_addr[`DCACHE_TAG_LSB-1:`DCACHE_INDEX_LSB];
            end
            WRITE_CACHE, REFILL: begin
                tag_enable = 1'b1;
                tag_write  = 1'b1;
            end
            default: begin
                tag_enable = 1'b0;
            end
        endcase
    end

    assign data_write  = (state == WRITE_CACHE) || (state == REFILL);
    assign data_enable = (state == READ_CACHE) || data_write;
    assign data_addr   = {index_q, way_q};
    assign data_wdata  = merged_line;

    assign merge_line     = (state == REFILL) ? refill_q : data_rdata;
    assign merge_word_sel = addr_q[`DCACHE_INDEX_LSB-1:`DCACHE_WORD_SEL_LSB];
    assign merge_wdata    = wdata_q;
    assign merge_wmask    = (op_q == dcache_pkg::OP_WRITE) ? wmask_q : '0;

    assign cpu_ready = (state == IDLE);
    assign cpu_done  = (state == RESPOND) || (state == WRITE_CACHE) || (state == REFILL);
    assign cpu_rdata = merged_word;

    assign mem_valid = ((state == WRITE_BACK) && !wb_sent) || (state == REFILL_REQ);
    assign mem_op    = (state == WRITE_BACK) ? dcache_pkg::OP_WRITE : dcache_pkg::OP_READ;
    assign mem_addr  = {(state == WRITE_BACK) ? victim_tag_q : lookup_tag, index_q,
                        {`DCACHE_OFFSET_BITS{1'b0}}};
    assign mem_wdata = data_rdata;   // victim line, read in READ_CACHE

    // request held until the memory takes it
    assert property (@(posedge clock) disable iff (!reset_n)
        mem_valid && !mem_ready |=> mem_valid && $stable(mem_addr) && $stable(mem_op));

endmodule

`default_nettype wire

//--- verilog/dcache_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "dcache_settings.svh"

module dcache_top (
    input  wire logic              clock,
    input  wire logic              reset_n,
    input  wire logic              cpu_valid,
    output logic                   cpu_ready,
    input  wire dcache_pkg::addr_t cpu_addr,
    input  wire dcache_pkg::op_t   cpu_op,
    input  wire dcache_pkg::word_t cpu_wdata,
    input  wire dcache_pkg::word_t cpu_wmask,
    output logic                   cpu_done,
    output dcache_pkg::word_t      cpu_rdata,
    output logic                   mem_valid,
    input  wire logic              mem_ready,
    output dcache_pkg::addr_t      mem_addr,
    output dcache_pkg::op_t        mem_op,
    output dcache_pkg::line_t      mem_wdata,
    input  wire logic              mem_done,
    input  wire dcache_pkg::line_t mem_rdata
);
    logic                                          tag_enable;
    logic                                          tag_write;
    logic [`DCACHE_INDEX_BITS-1:0]                 tag_addr;
    dcache_pkg::tag_set_t                          tag_wdata;
    dcache_pkg::tag_set_t                          tag_rdata;
    logic                                          data_enable;
    logic                                          data_write;
    logic [`DCACHE_INDEX_BITS+`DCACHE_WAY_BITS-1:0] data_addr;
    dcache_pkg::line_t                             data_wdata;
    dcache_pkg::line_t                             data_rdata;
    logic                                          hit;
    logic                                          hit_way;
    logic                                          victim_way;
    logic                                          victim_dirty;
    logic [`DCACHE_TAG_BITS-1:0]                   victim_tag;
    logic [`DCACHE_TAG_BITS-1:0]                   lookup_tag;
    logic                                          advance;
    dcache_pkg::line_t                             merge_line;
    logic [`DCACHE_WORD_SEL_BITS-1:0]              merge_word_sel;
    dcache_pkg::word_t                             merge_wdata;
    dcache_pkg::word_t                             merge_wmask;
    dcache_pkg::line_t                             merged_line;
    dcache_pkg::word_t                             merged_word;

    dcache_control u_control (
        .clock(clock), .reset_n(reset_n),
        .cpu_valid(cpu_valid), .cpu_ready(cpu_ready), .cpu_addr(cpu_addr),
        .cpu_op(cpu_op), .cpu_wdata(cpu_wdata), .cpu_wmask(cpu_wmask),
        .cpu_done(cpu_done), .cpu_rdata(cpu_rdata),
        .mem_valid(mem_valid), .mem_ready(mem_ready), .mem_addr(mem_addr),
        .mem_op(mem_op), .mem_wdata(mem_wdata), .mem_done(mem_done),
        .mem_rdata(mem_rdata),
        .tag_enable(tag_enable), .tag_write(tag_write), .tag_addr(tag_addr),
        .tag_wdata(tag_wdata), .tag_rdata(tag_rdata),
        .data_enable(data_enable), .data_write(data_write), .data_addr(data_addr),
        .data_wdata(data_wdata), .data_rdata(data_rdata),
        .hit(hit), .hit_way(hit_way), .victim_way(victim_way),
        .victim_dirty(victim_dirty), .victim_tag(victim_tag),
        .lookup_tag(lookup_tag), .advance(advance),
        .merge_line(merge_line), .merge_word_sel(merge_word_sel),
        .merge_wdata(merge_wdata), .merge_wmask(merge_wmask),
        .merged_line(merged_line), .merged_word(merged_word)
    );

    dcache_way_select u_way_select (
        .clock(clock), .reset_n(reset_n),
        .tag_set(tag_rdata), .lookup_tag(lookup_tag), .advance(advance),
        .hit(hit), .hit_way(hit_way), .victim_way(victim_way),
        .victim_dirty(victim_dirty), .victim_tag(victim_tag)
    );

    dcache_line_merge u_line_merge (
        .line_in(merge_line), .word_sel(merge_word_sel),
        .wdata(merge_wdata), .wmask(merge_wmask),
        .line_out(merged_line), .word_out(merged_word)
    );

    // one tag set per index
    dcache_sram #(.entry_t(dcache_pkg::tag_set_t), .DEPTH(`DCACHE_SETS)) tag_array (
        .clock(clock), .enable(tag_enable), .write(tag_write),
        .addr(tag_addr), .wdata(tag_wdata), .rdata(tag_rdata)
    );

    // one line per index and way
    dcache_sram #(
        .entry_t(dcache_pkg::line_t),
        .DEPTH(`DCACHE_SETS * `DCACHE_WAYS)
    ) data_array (
        .clock(clock), .enable(data_enable), .write(data_write),
        .addr(data_addr), .wdata(data_wdata), .rdata(data_rdata)
    );

endmodule

`default_nettype wire

//--- bench/dcache_mem_model.sv
`timescale 1ns/1ps
`default_nettype none
`include "dcache_settings.svh"

module dcache_mem_model (
    input  wire logic              clock,
    input  wire logic              delays_on,
    input  wire logic              mem_valid,
    output logic                   mem_ready,
    input  wire dcache_pkg::addr_t mem_addr,
    input  wire dcache_pkg::op_t   mem_op,
    input  wire dcache_pkg::line_t mem_wdata,
    output logic                   mem_done,
    output dcache_pkg::line_t      mem_rdata
);
    integer            seed = 32'h9494ed9c;
    dcache_pkg::line_t store [dcache_pkg::addr_t];
    dcache_pkg::line_t pristine [dcache_pkg::addr_t];   // contents before any write-back
    dcache_pkg::addr_t wb_addr [$];
    dcache_pkg::line_t wb_line [$];

    // a line gets its random contents on first touch
    task automatic fill_line(input dcache_pkg::addr_t line_addr);
        dcache_pkg::line_t fresh;
        if (!store.exists(line_addr)) begin
            for (int w = 0; w < `DCACHE_WORDS_PER_LINE; w++) begin
                fresh[w] = {$random(seed), $random(seed)};
            end
            store[line_addr]    = fresh;
            pristine[line_addr] = fresh;
        end
    endtask

    task automatic pick_delay(output int cycles);
        logic [31:0] r;
        r      = $random(seed);
        cycles = delays_on ? int'(r[1:0]) : 0;   // 0 to 3 cycles
    endtask

    task automatic step_cycle();
        @(posedge clock);
        #2;
    endtask

    initial begin : responder
        dcache_pkg::addr_t addr;
        dcache_pkg::op_t   op;
        dcache_pkg::line_t wline;
        int                delay;
        mem_ready = 1'b0;
        mem_done  = 1'b0;
        mem_rdata = '0;
        forever begin
            step_cycle();
            if (mem_valid) begin
                pick_delay(delay);
                repeat (delay) step_cycle();   // request is held meanwhile
                addr      = mem_addr;
                op        = mem_op;
                wline     = mem_wdata;
                mem_ready = 1'b1;
                step_cycle();                  // taken at this edge
                mem_ready = 1'b0;
                pick_delay(delay);
                repeat (delay) step_cycle();
                fill_line(addr);
                if (op == dcache_pkg::OP_WRITE) begin
                    store[addr] = wline;
                    wb_addr.push_back(addr);
                    wb_line.push_back(wline);
                end else begin
                    mem_rdata = store[addr];
                end
                mem_done = 1'b1;
                step_cycle();
                mem_done = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- bench/dcache_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "dcache_settings.svh"

module dcache_tb;
    localparam int INIT_CYCLES  = 3 + `DCACHE_SETS;
    localparam int EVICT_TRIES  = 12;
    localparam int MIX_LENGTH   = 40;
    // accesses of all tests, eviction retries included
    localparam int ACCESS_COUNT = 2 + 2 + 9 + (EVICT_TRIES + 2) + MIX_LENGTH;

    logic              clock;
    logic              reset_n;
    logic              cpu_valid;
    logic              cpu_ready;
    dcache_pkg::addr_t cpu_addr;
    dcache_pkg::op_t   cpu_op;
    dcache_pkg::word_t cpu_wdata;
    dcache_pkg::word_t cpu_wmask;
    logic              cpu_done;
    dcache_pkg::word_t cpu_rdata;
    logic              mem_valid;
    logic              mem_ready;
    dcache_pkg::addr_t mem_addr;
    dcache_pkg::op_t   mem_op;
    dcache_pkg::line_t mem_wdata;
    logic              mem_done;
    dcache_pkg::line_t mem_rdata;
    logic              delays_on;

    integer            seed = 32'h9494ed9c;
    int                errors = 0;
    int                checks = 0;
    int                wb_checked = 0;
    dcache_pkg::line_t shadow [dcache_pkg::addr_t];   // what the CPU should see

    dcache_top UUT (.*);
    dcache_mem_model mem_model (.*);

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    task automatic step_cycle();
        @(posedge clock);
        #2;
    endtask

    function automatic dcache_pkg::addr_t line_of(input dcache_pkg::addr_t a);
        return {a[`DCACHE_ADDR_BITS-1:`DCACHE_OFFSET_BITS], {`DCACHE_OFFSET_BITS{1'b0}}};
    endfunction

    function automatic dcache_pkg::addr_t make_addr(input logic [`DCACHE_TAG_BITS-1:0] tag,
                                                    input logic [`DCACHE_INDEX_BITS-1:0] index,
                                                    input logic [2:0] word);
        return {tag, index, word, 3'b000};
    endfunction

    task automatic load_shadow(input dcache_pkg::addr_t la);
        if (!shadow.exists(la)) begin
            mem_model.fill_line(la);
            shadow[la] = mem_model.pristine[la];
        end
    endtask

    task automatic cpu_access(input dcache_pkg::op_t op, input dcache_pkg::addr_t addr,
                              input dcache_pkg::word_t wdata, input dcache_pkg::word_t wmask,
                              output dcache_pkg::word_t rdata, output int cycles);
        logic ready_seen;
        logic done_seen;
        cpu_valid = 1'b1;
        cpu_addr  = addr;
        cpu_op    = op;
        cpu_wdata = wdata;
        cpu_wmask = wmask;
        do begin
            ready_seen = cpu_ready;
            step_cycle();
        end while (!ready_seen);
        cpu_valid = 1'b0;   // accepted at the last edge
        cycles    = 0;
        do begin
            if (cpu_ready !== 1'b0) begin
                errors++;
                $display("Error at %0t ns: cpu_ready high while 0x%h is in flight", $time, addr);
            end
            done_seen = cpu_done;
            rdata     = cpu_rdata;
            step_cycle();
            cycles++;
        end while (!done_seen);
    endtask

    // every new write-back must carry the line the CPU last saw
    task automatic check_writebacks();
        dcache_pkg::addr_t la;
        while (wb_checked < mem_model.wb_addr.size()) begin
            la = mem_model.wb_addr[wb_checked];
            checks++;
            if (!shadow.exists(la) || mem_model.wb_line[wb_checked] !== shadow[la]) begin
                errors++;
                $display("Error at %0t ns: write-back of line 0x%h holds wrong data", $time, la);
            end
            wb_checked++;
        end
    endtask

    task automatic do_read(input dcache_pkg::addr_t a, output int cycles);
        dcache_pkg::word_t expected;
        dcache_pkg::word_t got;
        load_shadow(line_of(a));
        expected = shadow[line_of(a)][a[`DCACHE_OFFSET_BITS-1:3]];
        cpu_access(dcache_pkg::OP_READ, a, '0, '0, got, cycles);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("Error at %0t ns: read of 0x%h gave 0x%h, expected 0x%h",
                     $time, a, got, expected);
        end
        check_writebacks();
    endtask

    task automatic do_write(input dcache_pkg::addr_t a, input dcache_pkg::word_t wdata,
                            input dcache_pkg::word_t wmask, output int cycles);
        dcache_pkg::word_t ignored;
        dcache_pkg::word_t merged;
        dcache_pkg::addr_t la;
        la = line_of(a);
        load_shadow(la);
        cpu_access(dcache_pkg::OP_WRITE, a, wdata, wmask, ignored, cycles);
        merged = shadow[la][a[`DCACHE_OFFSET_BITS-1:3]];
        for (int b = 0; b < `DCACHE_WORD_BITS; b++) begin
            if (wmask[b]) begin
                merged[b] = wdata[b];   // store bit replaces the old one
            end
        end
        shadow[la][a[`DCACHE_OFFSET_BITS-1:3]] = merged;
        check_writebacks();
    endtask

    task automatic check_latency(input int cycles, input string what);
        checks++;
        if (cycles != 3) begin
            errors++;
            $display("Error at %0t ns: %s took %0d cycles, expected 3", $time, what, cycles);
        end
    endtask

    task automatic read_miss_then_hit();
        int cycles;
        do_read(32'h0000_1058, cycles);
        do_read(32'h0000_1058, cycles);
        check_latency(cycles, "read hit");
    endtask

    task automatic write_hit_partial();
        int cycles;
        do_write(32'h0000_1058, 64'h1122_3344_5566_7788, 64'hFFFF_0000_FF00_00FF, cycles);
        check_latency(cycles, "write hit");
        do_read(32'h0000_1058, cycles);
    endtask

    task automatic write_miss_merge();
        int                cycles;
        dcache_pkg::addr_t base;
        base = 32'h0002_3140;
        do_write(base + 32'd40, 64'hDEAD_BEEF_0BAD_F00D, 64'h0000_FFFF_FFFF_0000, cycles);
        for (int w = 0; w < `DCACHE_WORDS_PER_LINE; w++) begin
            do_read(base + 32'(w * 8), cycles);   // merged word and untouched neighbours
        end
    endtask

    task automatic dirty_eviction();
        int                cycles;
        int                tries;
        int                wb_start;
        dcache_pkg::addr_t a0;
        dcache_pkg::addr_t a1;
        dcache_pkg::addr_t a2;
        a0       = make_addr(17'h00011, 9'h0A5, 3'd2);
        a1       = make_addr(17'h00022, 9'h0A5, 3'd2);
        a2       = make_addr(17'h00033, 9'h0A5, 3'd2);
        wb_start = mem_model.wb_addr.size();
        do_write(a0, 64'hCAFE_0000_1234_5678, '1, cycles);
        tries = 0;
        // alternate the other two tags until the LFSR picks the dirty way
        while (mem_model.wb_addr.size() == wb_start && tries < EVICT_TRIES) begin
            do_read((tries % 2 == 0) ? a1 : a2, cycles);
            tries++;
        end
        checks++;
        if (mem_model.wb_addr.size() == wb_start) begin
            errors++;
            $display("dirty line 0x%h was never written back after %0d misses", a0, tries);
        end else if (mem_model.wb_addr[wb_start] !== line_of(a0)) begin
            errors++;
            $display("Error at %0t ns: write-back went to 0x%h, expected 0x%h",
                     $time, mem_model.wb_addr[wb_start], line_of(a0));
        end
        do_read(a0, cycles);
    endtask

    task automatic back_pressure_mix();
        int                cycles;
        logic [31:0]       r;
        dcache_pkg::addr_t a;
        dcache_pkg::word_t wdata;
        dcache_pkg::word_t wmask;
        delays_on = 1'b1;
        for (int i = 0; i < MIX_LENGTH; i++) begin
            r     = $random(seed);
            a     = make_addr({15'h0040, r[1:0]}, {8'h08, r[2]}, r[5:3]);   // 4 tags, 2 sets
            wdata = {$random(seed), $random(seed)};
            wmask = {$random(seed), $random(seed)};
            if (r[6]) begin
                do_write(a, wdata, wmask, cycles);
            end else begin
                do_read(a, cycles);
            end
        end
    endtask

    initial begin
        reset_n   = 1'b0;
        cpu_valid = 1'b0;
        cpu_addr  = '0;
        cpu_op    = dcache_pkg::OP_READ;
        cpu_wdata = '0;
        cpu_wmask = '0;
        delays_on = 1'b0;
        repeat (3) @(posedge clock);
        #2 reset_n = 1'b1;
        read_miss_then_hit();
        write_hit_partial();
        write_miss_merge();
        dirty_eviction();
        back_pressure_mix();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin
        repeat (INIT_CYCLES + 200 * ACCESS_COUNT) @(posedge clock);
        $display("timeout: run still busy after %0d cycles, checks: %0d, errors: %0d",
                 INIT_CYCLES + 200 * ACCESS_COUNT, checks, errors);
        $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+verilog
verilog/dcache_pkg.sv
verilog/dcache_sram.sv
verilog/dcache_way_select.sv
verilog/dcache_line_merge.sv
verilog/dcache_control.sv
verilog/dcache_top.sv
bench/dcache_mem_model.sv
bench/dcache_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= dcache_tb
RTL_TOP   ?= dcache_top
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1 || echo "simulator exited with an error" >> $(LOG)
	@cat $(LOG)
	@! grep -q -e "Test FAILED" -e "simulator exited with an error" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
